/* Bender.yml */
package:
  name: pid_ctrl

sources:
  - logic/pid_pkg.sv
  - logic/pid_block.sv
  - logic/pid_sum_sat.sv
  - logic/pid_regs.sv
  - logic/pid_mimo_top.sv
  - target: test
    files:
      - test/pid_checker.sv
      - test/pid_tb.sv

/* logic/pid_block.sv */
////////////////////////////////////////////////////////////////////////////
// single PID cell
// error register, P/I/D products with integrator, sum and saturation
// three cycles from dat_i to dat_o
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module pid_block #(
  parameter int unsigned DWI = 14,  // input width
  parameter int unsigned DWO = 14,  // output width
  parameter int unsigned PSR = 12,  // proportional shift
  parameter int unsigned ISR = 18,  // integral shift
  parameter int unsigned DSR = 10   // derivative shift
) (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic signed [DWI-1:0]             dat_i,
  input  logic signed [pid_pkg::COEF_W-1:0] set_sp_i,
  input  logic signed [pid_pkg::COEF_W-1:0] set_kp_i,
  input  logic signed [pid_pkg::COEF_W-1:0] set_ki_i,
  input  logic signed [pid_pkg::COEF_W-1:0] set_kd_i,
  input  logic                              int_rst_i,
  output logic signed [DWO-1:0]             dat_o
);

  import pid_pkg::*;

  localparam int unsigned EW  = ((COEF_W > DWI) ? COEF_W : DWI) + 1;  // error
  localparam int unsigned PW  = EW + COEF_W;      // kp and ki products
  localparam int unsigned KDW = EW + 1 + COEF_W;  // kd product, diff is one wider
  // accumulator keeps DWO+1 bits above the shift, never narrower than a product
  localparam int unsigned IAW = ((ISR + DWO + 1) > (PW + 1)) ? (ISR + DWO + 1) : (PW + 1);
  localparam int unsigned SW  = ((IAW > KDW) ? IAW : KDW) + 2;  // final sum

  // output rails in sum width
  localparam logic signed [SW-1:0] OMAX = {{(SW-DWO+1){1'b0}}, {(DWO-1){1'b1}}};
  localparam logic signed [SW-1:0] OMIN = {{(SW-DWO+1){1'b1}}, {(DWO-1){1'b0}}};

  logic signed [EW-1:0]  err_r;       // stage 1
  logic signed [EW-1:0]  err_prev_r;  // stage 2, error one sample back
  logic signed [EW:0]    err_diff;
  logic signed [PW-1:0]  kp_r;
  logic signed [KDW-1:0] kd_r;
  logic signed [PW-1:0]  ki_prod;
  logic signed [IAW:0]   acc_sum;     // one guard bit for overflow detect
  logic signed [IAW-1:0] acc_r;
  logic signed [SW-1:0]  p_term;      // stage 3 operands
  logic signed [SW-1:0]  i_term;
  logic signed [SW-1:0]  d_term;
  logic signed [SW-1:0]  pid_sum;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1: error
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      err_r <= '0;
    end else begin
      err_r <= set_sp_i - dat_i;  // both sign extended to EW
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 2: products and integrator
  ////////////////////////////////////////////////////////////////////////////

  assign err_diff = err_r - err_prev_r;
  assign ki_prod  = err_r * set_ki_i;
  assign acc_sum  = acc_r + ki_prod;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      err_prev_r <= '0;
      kp_r       <= '0;
      kd_r       <= '0;
      acc_r      <= '0;
    end else begin
      err_prev_r <= err_r;
      kp_r       <= err_r * set_kp_i;
      kd_r       <= err_diff * set_kd_i;
      if (int_rst_i) begin
        acc_r <= '0;                             // integrator held
      end else if (acc_sum[IAW:IAW-1] == 2'b01) begin
        acc_r <= {1'b0, {(IAW-1){1'b1}}};        // positive rail
      end else if (acc_sum[IAW:IAW-1] == 2'b10) begin
        acc_r <= {1'b1, {(IAW-1){1'b0}}};        // negative rail
      end else begin
        acc_r <= acc_sum[IAW-1:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 3: scale, sum, saturate
  ////////////////////////////////////////////////////////////////////////////

  assign p_term  = kp_r >>> PSR;   // arithmetic shifts keep the sign
  assign i_term  = acc_r >>> ISR;
  assign d_term  = kd_r >>> DSR;
  assign pid_sum = p_term + i_term + d_term;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      dat_o <= '0;
    end else if (pid_sum > OMAX) begin
      dat_o <= OMAX[DWO-1:0];
    end else if (pid_sum < OMIN) begin
      dat_o <= OMIN[DWO-1:0];
    end else begin
      dat_o <= pid_sum[DWO-1:0];
    end
  end

  // reset bit must leave the integrator empty on the next cycle
  a_int_rst : assert property (
    @(posedge clk) disable iff (!rstn)
    int_rst_i |=> (acc_r == '0)
  );

endmodule

/* logic/pid_mimo_top.sv */
////////////////////////////////////////////////////////////////////////////
// MIMO PID controller top level
// register bank, CNO x CNI cell array, one row adder per output
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module pid_mimo_top #(
  parameter int unsigned DWI = 14,  // input width
  parameter int unsigned DWO = 14,  // output width
  parameter int unsigned CNI = 2,   // input channels
  parameter int unsigned CNO = 2,   // output channels
  parameter int unsigned PSR = 12,
  parameter int unsigned ISR = 18,
  parameter int unsigned DSR = 10
) (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic signed [CNI-1:0][DWI-1:0] dat_i,
  output logic signed [CNO-1:0][DWO-1:0] dat_o,
  input  logic                           bus_req_i,
  input  logic                           bus_we_i,
  input  logic [pid_pkg::BUS_AW-1:0]     bus_addr_i,
  input  logic [pid_pkg::BUS_DW-1:0]     bus_wdata_i,
  output logic                           bus_ack_o,
  output logic [pid_pkg::BUS_DW-1:0]     bus_rdata_o
);

  import pid_pkg::*;

  logic [CNO*CNI-1:0][COEF_W-1:0]   set_sp;
  logic [CNO*CNI-1:0][COEF_W-1:0]   set_kp;
  logic [CNO*CNI-1:0][COEF_W-1:0]   set_ki;
  logic [CNO*CNI-1:0][COEF_W-1:0]   set_kd;
  logic [CNO*CNI-1:0]               int_rst;
  logic [CNO-1:0][CNI-1:0][DWO-1:0] cell_dat;  // per-cell results, by row

  pid_regs #(
    .CNI (CNI),
    .CNO (CNO)
  ) u_regs (
    .clk         (clk),
    .rstn        (rstn),
    .bus_req_i   (bus_req_i),
    .bus_we_i    (bus_we_i),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_ack_o   (bus_ack_o),
    .bus_rdata_o (bus_rdata_o),
    .set_sp_o    (set_sp),
    .set_kp_o    (set_kp),
    .set_ki_o    (set_ki),
    .set_kd_o    (set_kd),
    .int_rst_o   (int_rst)
  );

  for (genvar o = 0; o < CNO; o++) begin : g_out
    for (genvar i = 0; i < CNI; i++) begin : g_in
      pid_block #(
        .DWI (DWI),
        .DWO (DWO),
        .PSR (PSR),
        .ISR (ISR),
        .DSR (DSR)
      ) u_cell (
        .clk       (clk),
        .rstn      (rstn),
        .dat_i     (dat_i[i]),              // input channel i feeds every row
        .set_sp_i  (set_sp[o*CNI+i]),
        .set_kp_i  (set_kp[o*CNI+i]),
        .set_ki_i  (set_ki[o*CNI+i]),
        .set_kd_i  (set_kd[o*CNI+i]),
        .int_rst_i (int_rst[o*CNI+i]),
        .dat_o     (cell_dat[o][i])
      );
    end

    pid_sum_sat #(
      .CNI (CNI),
      .DWO (DWO)
    ) u_sum (
      .clk    (clk),
      .rstn   (rstn),
      .term_i (cell_dat[o]),
      .dat_o  (dat_o[o])
    );
  end

endmodule

/* logic/pid_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared definitions of the MIMO PID controller
// register port widths, coefficient width, register map offsets
// and reset values of the settings
////////////////////////////////////////////////////////////////////////////

package pid_pkg;

  // register port
  localparam int unsigned BUS_AW = 8;   // byte address
  localparam int unsigned BUS_DW = 32;  // read and write data

  // every set point and gain is a signed value of this width
  localparam int unsigned COEF_W = 14;

  //////////////////////////////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////////////////////////////

  // integrator reset bits, bit index = output * CNI + input
  localparam int unsigned REG_IRST = 0;

  // cell (o, i) window at REG_CELL_BASE + 16 * (o * CNI + i)
  localparam int unsigned REG_CELL_BASE = 16;

  // offsets inside a 16 byte cell window
  localparam int unsigned OFS_SP = 0;   // set point
  localparam int unsigned OFS_KP = 4;   // proportional gain
  localparam int unsigned OFS_KI = 8;   // integral gain
  localparam int unsigned OFS_KD = 12;  // derivative gain

  //////////////////////////////////////////////////////////////////////////
  // reset values
  //////////////////////////////////////////////////////////////////////////

  localparam logic                     IRST_RESET = 1'b1;  // integrators held
  localparam logic signed [COEF_W-1:0] COEF_RESET = '0;    // all gains off

endpackage

/* logic/pid_regs.sv */
////////////////////////////////////////////////////////////////////////////
// settings register bank
// four-phase req/ack slave, set points, gains and integrator resets
// flat per-cell outputs, index = output * CNI + input
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module pid_regs #(
  parameter int unsigned CNI = 2,
  parameter int unsigned CNO = 2
) (
  input  logic                                    clk,
  input  logic                                    rstn,
  input  logic                                    bus_req_i,
  input  logic                                    bus_we_i,
  input  logic [pid_pkg::BUS_AW-1:0]              bus_addr_i,
  input  logic [pid_pkg::BUS_DW-1:0]              bus_wdata_i,
  output logic                                    bus_ack_o,
  output logic [pid_pkg::BUS_DW-1:0]              bus_rdata_o,
  output logic [CNO*CNI-1:0][pid_pkg::COEF_W-1:0] set_sp_o,
  output logic [CNO*CNI-1:0][pid_pkg::COEF_W-1:0] set_kp_o,
  output logic [CNO*CNI-1:0][pid_pkg::COEF_W-1:0] set_ki_o,
  output logic [CNO*CNI-1:0][pid_pkg::COEF_W-1:0] set_kd_o,
  output logic [CNO*CNI-1:0]                      int_rst_o
);

  import pid_pkg::*;

  localparam int unsigned NC  = CNO * CNI;   // number of cells
  localparam int unsigned CIW = BUS_AW - 4;  // cell index, 16 byte windows

  logic              acc_en;       // one access per req phase
  logic [BUS_AW-1:0] cell_ofs;
  logic [CIW-1:0]    cell_idx;
  logic [3:0]        win_ofs;
  logic              cell_hit;
  logic              irst_hit;
  logic [COEF_W-1:0] rd_coef;
  logic              rd_coef_vld;
  logic [BUS_DW-1:0] rd_data;

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  assign acc_en   = bus_req_i && !bus_ack_o;  // phase 1 seen, not yet acked
  assign cell_ofs = bus_addr_i - BUS_AW'(REG_CELL_BASE);
  assign cell_idx = cell_ofs[BUS_AW-1:4];
  assign win_ofs  = cell_ofs[3:0];
  assign cell_hit = (bus_addr_i >= BUS_AW'(REG_CELL_BASE)) && (cell_idx < NC);
  assign irst_hit = (bus_addr_i == BUS_AW'(REG_IRST));

  // coefficient readback mux, unaligned offsets unmapped
  always_comb begin
    rd_coef     = '0;
    rd_coef_vld = 1'b0;
    if (cell_hit) begin
      rd_coef_vld = 1'b1;
      case (win_ofs)
        4'(OFS_SP): rd_coef = set_sp_o[cell_idx];
        4'(OFS_KP): rd_coef = set_kp_o[cell_idx];
        4'(OFS_KI): rd_coef = set_ki_o[cell_idx];
        4'(OFS_KD): rd_coef = set_kd_o[cell_idx];
        default:    rd_coef_vld = 1'b0;
      endcase
    end
  end

  always_comb begin
    rd_data = '0;                                   // unmapped reads zero
    if (irst_hit) begin
      rd_data[NC-1:0] = int_rst_o;                  // zero extended
    end else if (rd_coef_vld) begin
      rd_data = {{(BUS_DW-COEF_W){rd_coef[COEF_W-1]}}, rd_coef};  // sign extended
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // settings, written on the edge that raises ack
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      set_sp_o  <= {NC{COEF_RESET}};
      set_kp_o  <= {NC{COEF_RESET}};
      set_ki_o  <= {NC{COEF_RESET}};
      set_kd_o  <= {NC{COEF_RESET}};
      int_rst_o <= {NC{IRST_RESET}};
    end else if (acc_en && bus_we_i) begin
      if (irst_hit) begin
        int_rst_o <= bus_wdata_i[NC-1:0];
      end
      if (cell_hit) begin
        case (win_ofs)
          4'(OFS_SP): set_sp_o[cell_idx] <= bus_wdata_i[COEF_W-1:0];
          4'(OFS_KP): set_kp_o[cell_idx] <= bus_wdata_i[COEF_W-1:0];
          4'(OFS_KI): set_ki_o[cell_idx] <= bus_wdata_i[COEF_W-1:0];
          4'(OFS_KD): set_kd_o[cell_idx] <= bus_wdata_i[COEF_W-1:0];
          default: ;                                // hole in the window
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      bus_ack_o   <= 1'b0;
      bus_rdata_o <= '0;
    end else if (acc_en) begin
      bus_ack_o   <= 1'b1;                          // phase 2
      bus_rdata_o <= bus_we_i ? '0 : rd_data;       // held while ack high
    end else if (!bus_req_i && bus_ack_o) begin
      bus_ack_o <= 1'b0;                            // phase 4
    end
  end

  a_ack_rise : assert property (
    @(posedge clk) disable iff (!rstn)
    (!bus_req_i && !bus_ack_o) |=> !bus_ack_o
  );
  a_ack_fall : assert property (
    @(posedge clk) disable iff (!rstn)
    (bus_req_i && bus_ack_o) |=> bus_ack_o
  );

endmodule

/* logic/pid_sum_sat.sv */
////////////////////////////////////////////////////////////////////////////
// row adder for one output channel
// sums the cell results and clamps to the output range, one cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module pid_sum_sat #(
  parameter int unsigned CNI = 2,   // terms per row
  parameter int unsigned DWO = 14   // term and output width
) (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic signed [CNI-1:0][DWO-1:0] term_i,
  output logic signed [DWO-1:0]          dat_o
);

  // room for CNI full scale terms without wrap
  localparam int unsigned SW = DWO + $clog2(CNI);

  localparam logic signed [SW-1:0] OMAX = {{(SW-DWO+1){1'b0}}, {(DWO-1){1'b1}}};
  localparam logic signed [SW-1:0] OMIN = {{(SW-DWO+1){1'b1}}, {(DWO-1){1'b0}}};

  logic signed [SW-1:0] sum_c;

  // signed sum over the row
  always_comb begin
    sum_c = '0;
    for (int i = 0; i < CNI; i++) begin
      sum_c = sum_c + $signed(term_i[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      dat_o <= '0;
    end else if (sum_c > OMAX) begin
      dat_o <= OMAX[DWO-1:0];    // clamp high
    end else if (sum_c < OMIN) begin
      dat_o <= OMIN[DWO-1:0];    // clamp low
    end else begin
      dat_o <= sum_c[DWO-1:0];
    end
  end

  // clamping pulls a sum toward zero and never flips its sign
  a_sat_pos : assert property (
    @(posedge clk) disable iff (!rstn)
    (sum_c >= 0) |=> (dat_o >= 0) && (dat_o <= $past(sum_c))
  );
  a_sat_neg : assert property (
    @(posedge clk) disable iff (!rstn)
    (sum_c < 0) |=> (dat_o < 0) && (dat_o >= $past(sum_c))
  );

endmodule

/* pid_ctrl.f */
logic/pid_pkg.sv
logic/pid_block.sv
logic/pid_sum_sat.sv
logic/pid_regs.sv
logic/pid_mimo_top.sv
test/pid_checker.sv
test/pid_tb.sv

/* test/pid_checker.sv */
////////////////////////////////////////////////////////////////////////////
// testbench checker for the MIMO PID controller
// settings mirror from observed bus writes, cycle model of cells and sums
// compares dat_o, read data and the req/ack order, counts results
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module pid_checker #(
  parameter int unsigned DWI = 14,
  parameter int unsigned DWO = 14,
  parameter int unsigned CNI = 2,
  parameter int unsigned CNO = 2,
  parameter int unsigned PSR = 12,
  parameter int unsigned ISR = 18,
  parameter int unsigned DSR = 10
) (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic signed [CNI-1:0][DWI-1:0] in_dat_i,   // DUT dat_i
  input  logic signed [CNO-1:0][DWO-1:0] out_dat_i,  // DUT dat_o
  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [pid_pkg::BUS_AW-1:0]     addr_i,
  input  logic [pid_pkg::BUS_DW-1:0]     wdata_i,
  input  logic                           ack_i,
  input  logic [pid_pkg::BUS_DW-1:0]     rdata_i,
  output int                             err_cnt_o,
  output int                             chk_cnt_o,
  output int                             pass_cnt_o,
  output int                             fail_cnt_o
);

  import pid_pkg::*;

  localparam int NC    = CNO * CNI;
  localparam int LAT   = 4;              // dat_i to dat_o, cycles
  localparam int ACC_W = ISR + DWO + 1;  // integrator range, full output scale plus guard

  longint s_sp [NC];                     // settings mirror
  longint s_kp [NC];
  longint s_ki [NC];
  longint s_kd [NC];
  logic [NC-1:0] s_irst;
  longint m_err [NC];                    // cell model, one entry per pipeline register
  longint m_prev [NC];
  longint m_kp [NC];
  longint m_kd [NC];
  longint m_acc [NC];
  longint m_cell [NC];
  longint m_out [CNO];                   // row sums
  int live_cyc;                          // edges since reset release
  logic rd_pend;
  logic [BUS_DW-1:0] rd_exp;
  logic [BUS_AW-1:0] rd_addr;
  logic req_q, ack_q;
  int test_err, test_chk;

  initial begin
    err_cnt_o  = 0;
    chk_cnt_o  = 0;
    pass_cnt_o = 0;
    fail_cnt_o = 0;
    test_err   = 0;
    test_chk   = 0;
  end

  function automatic longint clamp(input longint v, input int w);
    longint hi;
    longint lo;
    hi = (64'sd1 << (w - 1)) - 1;
    lo = -(64'sd1 << (w - 1));
    if (v > hi) return hi;
    if (v < lo) return lo;
    return v;
  endfunction

  function automatic longint coef(input logic [BUS_DW-1:0] d);
    return longint'($signed(d[COEF_W-1:0]));  // low bits kept, sign extended
  endfunction

  function automatic logic [BUS_DW-1:0] exp_read(input logic [BUS_AW-1:0] addr);
    int rel;
    int c;
    logic [BUS_DW-1:0] v;
    rel = int'(addr) - int'(REG_CELL_BASE);
    c   = rel / 16;
    v   = '0;                            // holes read zero
    if (int'(addr) == int'(REG_IRST)) begin
      v[NC-1:0] = s_irst;
    end else if (rel >= 0 && c < NC) begin
      case (rel % 16)
        OFS_SP:  v = BUS_DW'(s_sp[c]);
        OFS_KP:  v = BUS_DW'(s_kp[c]);
        OFS_KI:  v = BUS_DW'(s_ki[c]);
        OFS_KD:  v = BUS_DW'(s_kd[c]);
        default: v = '0;
      endcase
    end
    return v;
  endfunction

  task automatic mirror_write(input logic [BUS_AW-1:0] addr, input logic [BUS_DW-1:0] d);
    int rel;
    int c;
    rel = int'(addr) - int'(REG_CELL_BASE);
    c   = rel / 16;
    if (int'(addr) == int'(REG_IRST)) begin
      s_irst = d[NC-1:0];
    end else if (rel >= 0 && c < NC) begin
      case (rel % 16)
        OFS_SP:  s_sp[c] = coef(d);
        OFS_KP:  s_kp[c] = coef(d);
        OFS_KI:  s_ki[c] = coef(d);
        OFS_KD:  s_kd[c] = coef(d);
        default: ;
      endcase
    end
  endtask

  task automatic reset_model();
    for (int c = 0; c < NC; c++) begin
      s_sp[c]   = COEF_RESET;
      s_kp[c]   = COEF_RESET;
      s_ki[c]   = COEF_RESET;
      s_kd[c]   = COEF_RESET;
      m_err[c]  = 0;
      m_prev[c] = 0;
      m_kp[c]   = 0;
      m_kd[c]   = 0;
      m_acc[c]  = 0;
      m_cell[c] = 0;
    end
    for (int o = 0; o < CNO; o++) begin
      m_out[o] = 0;
    end
    s_irst   = {NC{IRST_RESET}};
    live_cyc = 0;
    rd_pend  = 1'b0;
    req_q    = 1'b0;
    ack_q    = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one clock of the data path, later stages first so each sees old values
  ////////////////////////////////////////////////////////////////////////////

  task automatic step_model();
    longint sum;
    for (int o = 0; o < CNO; o++) begin
      sum = 0;
      for (int i = 0; i < CNI; i++) begin
        sum += m_cell[o*CNI+i];
      end
      m_out[o] = clamp(sum, DWO);        // row adder
    end
    for (int c = 0; c < NC; c++) begin
      m_cell[c] = clamp((m_kp[c] >>> PSR) + (m_acc[c] >>> ISR) + (m_kd[c] >>> DSR), DWO);
      m_kp[c]   = m_err[c] * s_kp[c];
      m_kd[c]   = (m_err[c] - m_prev[c]) * s_kd[c];
      m_acc[c]  = s_irst[c] ? 0 : clamp(m_acc[c] + m_err[c] * s_ki[c], ACC_W);
      m_prev[c] = m_err[c];
      m_err[c]  = s_sp[c] - longint'($signed(in_dat_i[c % CNI]));
    end
  endtask

  task automatic note_error();
    err_cnt_o++;
    test_err++;
  endtask

  task automatic check_value(input string what, input longint got, input longint exp);
    chk_cnt_o++;
    test_chk++;
    if (got != exp) begin
      $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      note_error();
    end
  endtask

  // called by the testbench when a test ends
  task report_test(input string name);
    if (test_err == 0) pass_cnt_o++;
    else fail_cnt_o++;
    $display("test %s: %0d checks, %0d errors", name, test_chk, test_err);
    test_err = 0;
    test_chk = 0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sampling at the rising edge, DUT values still from before the edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rstn) begin
      reset_model();
    end else begin
      if (live_cyc >= LAT) begin
        for (int o = 0; o < CNO; o++) begin
          check_value($sformatf("dat_o[%0d]", o), longint'($signed(out_dat_i[o])), m_out[o]);
        end
      end else begin
        live_cyc++;
      end
      if (rd_pend && ack_i) begin        // rdata valid while ack high
        check_value($sformatf("read of 0x%02h", rd_addr), longint'(rdata_i), longint'(rd_exp));
        rd_pend = 1'b0;
      end
      if (ack_i && !ack_q && !req_q) begin
        $display("bus order broken at %0t ns: ack rose while req was low", $time);
        note_error();
      end
      if (!ack_i && ack_q && req_q) begin
        $display("bus order broken at %0t ns: ack fell while req was still high", $time);
        note_error();
      end
      req_q = req_i;
      ack_q = ack_i;
      step_model();                      // uses settings from before this edge
      if (req_i && !ack_i) begin         // the access edge
        if (we_i) begin
          mirror_write(addr_i, wdata_i);
        end else begin
          rd_exp  = exp_read(addr_i);
          rd_addr = addr_i;
          rd_pend = 1'b1;
        end
      end
    end
  end

endmodule

/* test/pid_tb.sv */
////////////////////////////////////////////////////////////////////////////
// testbench top for the MIMO PID controller
// clock, reset, four-phase bus tasks, stimulus table, watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module pid_tb;

  import pid_pkg::*;

  localparam int DWI = 14;
  localparam int DWO = 14;
  localparam int CNI = 2;
  localparam int CNO = 2;
  localparam int NC  = CNO * CNI;
  localparam int NTEST    = 6;
  localparam int HOLD_CYC = 40;                        // input hold per test
  localparam int ACC_CNT  = 2 * (4 * NC + 1) + 2;      // writes, readbacks, hole reads
  localparam int TEST_CYC = ACC_CNT * 4 + HOLD_CYC;    // an access takes at most 4
  localparam int MAX_CYC  = (NTEST + 1) * TEST_CYC + 200;

  //////////////////////////////////////////////////////////////////////////
  // stimulus table, cells in order (0,0) (0,1) (1,0) (1,1)
  //////////////////////////////////////////////////////////////////////////

  string tab_name [NTEST] = '{"proportional", "integral", "int_reset",
                              "derivative", "saturation", "random"};
  int tab_sp [NTEST*4] = '{100, -50, 200, 0,  4000, 0, 4000, 0,  4000, 0, 4000, 0,
                           0, 0, 0, 0,  0, 0, 0, 0,  0, 0, 0, 0};
  int tab_kp [NTEST*4] = '{4096, 2048, -1024, 4096,  0, 0, 0, 0,  0, 0, 0, 0,
                           0, 0, 0, 0,  8191, 8191, -8192, -8192,  0, 0, 0, 0};
  int tab_ki [NTEST*4] = '{0, 0, 0, 0,  8000, 0, -8000, 0,  8000, 0, -8000, 0,
                           0, 0, 0, 0,  0, 0, 0, 0,  0, 0, 0, 0};
  int tab_kd [NTEST*4] = '{0, 0, 0, 0,  0, 0, 0, 0,  0, 0, 0, 0,
                           4096, 0, 0, -4096,  0, 0, 0, 0,  0, 0, 0, 0};
  int tab_irst [NTEST] = '{'hf, 'h0, 'hf, 'hf, 'hf, 'h0};
  int tab_in0 [NTEST]  = '{1000, -4000, -4000, -3000, -8000, 0};
  int tab_in1 [NTEST]  = '{-2000, 0, 0, 500, -8000, 0};
  bit tab_rnd [NTEST]  = '{0, 0, 0, 0, 0, 1};          // random settings and inputs

  logic clk;
  logic rstn;
  logic signed [CNI-1:0][DWI-1:0] dat_i;
  logic signed [CNO-1:0][DWO-1:0] dat_o;
  logic bus_req, bus_we, bus_ack;
  logic [BUS_AW-1:0] bus_addr;
  logic [BUS_DW-1:0] bus_wdata, bus_rdata;
  int err_cnt, chk_cnt, pass_cnt, fail_cnt;
  int cyc_cnt = 0;
  int unsigned rnd_first;

  pid_mimo_top #(.DWI(DWI), .DWO(DWO), .CNI(CNI), .CNO(CNO)) u_dut (
    .clk (clk), .rstn (rstn), .dat_i (dat_i), .dat_o (dat_o),
    .bus_req_i (bus_req), .bus_we_i (bus_we), .bus_addr_i (bus_addr),
    .bus_wdata_i (bus_wdata), .bus_ack_o (bus_ack), .bus_rdata_o (bus_rdata)
  );

  pid_checker #(.DWI(DWI), .DWO(DWO), .CNI(CNI), .CNO(CNO)) u_chk (
    .clk (clk), .rstn (rstn), .in_dat_i (dat_i), .out_dat_i (dat_o),
    .req_i (bus_req), .we_i (bus_we), .addr_i (bus_addr), .wdata_i (bus_wdata),
    .ack_i (bus_ack), .rdata_i (bus_rdata), .err_cnt_o (err_cnt),
    .chk_cnt_o (chk_cnt), .pass_cnt_o (pass_cnt), .fail_cnt_o (fail_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;                            // 40 ns period
  end

  always @(posedge clk) begin                          // watchdog
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= MAX_CYC) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYC);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // one four-phase access, starts and ends on a falling edge
  task automatic bus_access(input logic we, input logic [BUS_AW-1:0] addr,
                            input logic [BUS_DW-1:0] data);
    @(negedge clk);
    bus_we    = we;
    bus_addr  = addr;
    bus_wdata = data;
    bus_req   = 1'b1;
    do @(negedge clk); while (!bus_ack);               // wait for ack
    bus_req = 1'b0;
    do @(negedge clk); while (bus_ack);                // wait for ack release
    bus_we = 1'b0;
  endtask

  function automatic logic [BUS_AW-1:0] cell_addr(input int c, input int ofs);
    return BUS_AW'(REG_CELL_BASE + 16 * c + ofs);
  endfunction

  task automatic read_all();
    for (int c = 0; c < NC; c++) begin
      bus_access(1'b0, cell_addr(c, OFS_SP), '0);
      bus_access(1'b0, cell_addr(c, OFS_KP), '0);
      bus_access(1'b0, cell_addr(c, OFS_KI), '0);
      bus_access(1'b0, cell_addr(c, OFS_KD), '0);
    end
    bus_access(1'b0, BUS_AW'(REG_IRST), '0);
    bus_access(1'b0, 8'h04, '0);                       // hole below the windows
    bus_access(1'b0, cell_addr(NC, OFS_SP), '0);       // past the last cell
  endtask

  task automatic write_settings(input int t);
    int k;
    for (int c = 0; c < NC; c++) begin
      k = t * NC + c;
      bus_access(1'b1, cell_addr(c, OFS_SP), tab_rnd[t] ? $urandom : BUS_DW'(tab_sp[k]));
      bus_access(1'b1, cell_addr(c, OFS_KP), tab_rnd[t] ? $urandom : BUS_DW'(tab_kp[k]));
      bus_access(1'b1, cell_addr(c, OFS_KI), tab_rnd[t] ? $urandom : BUS_DW'(tab_ki[k]));
      bus_access(1'b1, cell_addr(c, OFS_KD), tab_rnd[t] ? $urandom : BUS_DW'(tab_kd[k]));
    end
    // reset bits last so integrators start from the new gains
    bus_access(1'b1, BUS_AW'(REG_IRST), tab_rnd[t] ? $urandom : BUS_DW'(tab_irst[t]));
  endtask

  task automatic hold_inputs(input int t);
    repeat (HOLD_CYC) begin
      @(negedge clk);
      dat_i[0] = tab_rnd[t] ? DWI'($urandom) : DWI'(tab_in0[t]);
      dat_i[1] = tab_rnd[t] ? DWI'($urandom) : DWI'(tab_in1[t]);
    end
  endtask

  initial begin
    rnd_first = $urandom(32'h116a_6fe0);
    rstn      = 1'b0;
    dat_i     = '0;
    bus_req   = 1'b0;
    bus_we    = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    read_all();                                        // reset values
    u_chk.report_test("reset_values");
    for (int t = 0; t < NTEST; t++) begin
      write_settings(t);
      read_all();
      hold_inputs(t);
      u_chk.report_test(tab_name[t]);
    end
    @(negedge clk);                                    // let the counters settle
    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             pass_cnt, fail_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0 && chk_cnt > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
